//--- design/bridge_settings.svh
// Medipix bridge settings
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Payload bytes carried by one OMR write frame.
`define MDPX_OMR_BYTES 6

// Width of the Operation Mode Register.
`define MDPX_OMR_BITS 48

// System clock cycles in each half of the serial chip clock.
// A value of 1 gives a chip clock of half the system clock.
`define MDPX_HALF_PERIOD 1

`endif

//--- design/mdpx_omr_pkg.sv
// Medipix OMR layout
`default_nettype none

`include "bridge_settings.svh"

package mdpx_omr_pkg;

  // The OMR arrives as bytes from the host but is read by fields.
  // The first byte received lands in bytes[5], the top of the register.
  typedef union packed {
    logic [`MDPX_OMR_BYTES-1:0][7:0] bytes;
    struct packed {
      logic [2:0] m;
      logic       crw_srw;
      logic       polarity;
      logic [1:0] ps;
      logic       disc_csm_spm;
      logic       enable_tp;
      logic [1:0] count_l;
      logic [2:0] column_block;
      logic       column_blocksel;
      logic [2:0] row_block;
      logic       row_blocksel;
      logic       equalization;
      logic       colour_mode;
      logic       csm_spm;
      logic       info_header;
      logic [5:0] fuse_sel;
      logic [5:0] fuse_pulse_wd;
      logic [1:0] gain_mode;
      logic [4:0] sense_dac;
      logic [4:0] ext_dac;
      logic       ext_bg_sel;
    } fields;
  } omr_t;

endpackage

`default_nettype wire

//--- design/bridge_cmd_pkg.sv
// Host command encoding
`default_nettype none

package bridge_cmd_pkg;

  // Opcode bytes, sent with sync_nios high.
  parameter logic [7:0] OP_WRITE_OMR  = 8'h01;
  parameter logic [7:0] OP_SET_LEVELS = 8'h02;

  // Bit positions inside the control-level payload byte.
  parameter int unsigned CTL_SHUTTER    = 0;
  parameter int unsigned CTL_CHIP_RESET = 1;
  parameter int unsigned CTL_CONT_SEL   = 2;
  parameter int unsigned CTL_MTX_CLR    = 3;
  parameter int unsigned CTL_TPSWT      = 4;

endpackage

`default_nettype wire

//--- design/omr_decoder.sv
// Host frame decoder
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module omr_decoder (
  input  logic               clk_nios,
  input  logic               rst_n,
  input  logic               en_nios,
  input  logic               sync_nios,
  input  logic [7:0]         data_nios,
  input  logic               busy,
  output mdpx_omr_pkg::omr_t omr,
  output logic               send_omr,
  output logic               shutter,
  output logic               chip_reset,
  output logic               cont_sel,
  output logic               mtx_clr,
  output logic               tpswt
);

  import mdpx_omr_pkg::*;
  import bridge_cmd_pkg::*;

  localparam int unsigned IDX_W = $clog2(`MDPX_OMR_BYTES + 1);

  logic             en_q;
  logic             sync_q;
  logic [7:0]       data_q;
  logic [7:0]       opcode;
  logic [IDX_W-1:0] idx;
  omr_t             stage;
  logic             payload;
  logic             omr_byte;
  logic             omr_done;

  // Host bytes are registered once before they are decoded.
  always_ff @(posedge clk_nios) begin
    if (!rst_n) begin
      en_q <= 1'b0;
    end else begin
      en_q <= en_nios;
    end
  end

  always_ff @(posedge clk_nios) begin
    sync_q <= sync_nios;
    data_q <= data_nios;
  end

  assign payload  = en_q && !sync_q;
  assign omr_byte = payload && (opcode == OP_WRITE_OMR) && (idx < IDX_W'(`MDPX_OMR_BYTES));
  assign omr_done = omr_byte && (idx == IDX_W'(`MDPX_OMR_BYTES - 1));

  // The last byte goes straight to omr, so the staging copy is one byte short then.
  always_ff @(posedge clk_nios) begin
    if (omr_byte) begin
      stage.bytes[`MDPX_OMR_BYTES - 1 - idx] <= data_q;
    end
    if (omr_done && !busy) begin
      omr          <= stage;
      omr.bytes[0] <= data_q;
    end
  end

  always_ff @(posedge clk_nios) begin
    if (!rst_n) begin
      // Opcode 0x00 is unknown, so payload is ignored until a real opcode.
      opcode     <= 8'h00;
      idx        <= '0;
      send_omr   <= 1'b0;
      shutter    <= 1'b0;
      chip_reset <= 1'b0;
      cont_sel   <= 1'b0;
      mtx_clr    <= 1'b0;
      tpswt      <= 1'b0;
    end else begin
      // A write that completes during a burst is dropped here.
      send_omr <= omr_done && !busy;
      if (en_q && sync_q) begin
        opcode <= data_q;
        idx    <= '0;
      end else if (omr_byte) begin
        idx <= idx + 1'b1;
      end else if (payload && (opcode == OP_SET_LEVELS) && (idx == '0)) begin
        shutter    <= data_q[CTL_SHUTTER];
        chip_reset <= data_q[CTL_CHIP_RESET];
        cont_sel   <= data_q[CTL_CONT_SEL];
        mtx_clr    <= data_q[CTL_MTX_CLR];
        tpswt      <= data_q[CTL_TPSWT];
        idx        <= IDX_W'(1);
      end
    end
  end

endmodule

`default_nettype wire

//--- design/omr_burst.sv
// OMR serializer
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module omr_burst (
  input  logic               clk_nios,
  input  logic               rst_n,
  input  logic               send_omr,
  input  mdpx_omr_pkg::omr_t omr,
  output logic               busy,
  output logic               ser_clk,
  output logic               ser_data,
  output logic               ser_en,
  output logic [2:0]         omr_mode
);

  localparam int unsigned HALF_W = (`MDPX_HALF_PERIOD > 1) ? $clog2(`MDPX_HALF_PERIOD) : 1;
  localparam int unsigned BIT_W  = $clog2(`MDPX_OMR_BITS);

  logic [`MDPX_OMR_BITS-1:0] shreg;
  logic [HALF_W-1:0]         phase_cnt;
  logic [BIT_W-1:0]          bit_cnt;
  logic                      phase_end;
  logic                      last_bit;

  assign phase_end = (phase_cnt == HALF_W'(`MDPX_HALF_PERIOD - 1));
  assign last_bit  = (bit_cnt == BIT_W'(`MDPX_OMR_BITS - 1));

  // Each bit is one low and one high half-period of ser_clk.
  // The burst ends on the falling edge after the last high phase.
  always_ff @(posedge clk_nios) begin
    if (!rst_n) begin
      ser_en    <= 1'b0;
      ser_clk   <= 1'b0;
      phase_cnt <= '0;
      bit_cnt   <= '0;
      omr_mode  <= 3'd0;
    end else if (send_omr) begin
      ser_en    <= 1'b1;
      ser_clk   <= 1'b0;
      phase_cnt <= '0;
      bit_cnt   <= '0;
      omr_mode  <= omr.fields.m;
    end else if (ser_en) begin
      if (phase_end) begin
        phase_cnt <= '0;
        ser_clk   <= ~ser_clk;
        if (ser_clk) begin
          if (last_bit) begin
            ser_en <= 1'b0;
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end
      end else begin
        phase_cnt <= phase_cnt + 1'b1;
      end
    end
  end

  // Shift on the falling edge so data holds through the whole high phase.
  always_ff @(posedge clk_nios) begin
    if (send_omr) begin
      shreg <= omr;
    end else if (ser_en && ser_clk && phase_end) begin
      shreg <= {shreg[`MDPX_OMR_BITS-2:0], 1'b0};
    end
  end

  assign ser_data = ser_en && shreg[`MDPX_OMR_BITS-1];
  assign busy     = ser_en;

endmodule

`default_nettype wire

//--- design/mdpx_pin_driver.sv
// Medipix pin registers
`timescale 1ns/1ps
`default_nettype none

module mdpx_pin_driver (
  input  logic       clk_nios,
  input  logic       rst_n,
  input  logic       shutter,
  input  logic       chip_reset,
  input  logic       cont_sel,
  input  logic       mtx_clr,
  input  logic       tpswt,
  input  logic       ser_clk,
  input  logic       ser_data,
  input  logic       ser_en,
  input  logic [2:0] omr_mode,
  output logic       clk_mdpx,
  output logic       data_mdpx,
  output logic       en_mdpx,
  output logic       shutter_mdpx,
  output logic       reset_mdpx,
  output logic       cont_sel_mdpx,
  output logic       mtx_clr_mdpx,
  output logic       tpswt_mdpx,
  output logic [2:0] m
);

  logic ser_en_q;
  logic ser_en_rise;

  assign ser_en_rise = ser_en && !ser_en_q;

  // All pins leave from flops so the chip never sees decode glitches.
  always_ff @(posedge clk_nios) begin
    if (!rst_n) begin
      ser_en_q      <= 1'b0;
      clk_mdpx      <= 1'b0;
      data_mdpx     <= 1'b0;
      en_mdpx       <= 1'b0;
      shutter_mdpx  <= 1'b0;
      reset_mdpx    <= 1'b0;
      cont_sel_mdpx <= 1'b0;
      mtx_clr_mdpx  <= 1'b0;
      tpswt_mdpx    <= 1'b0;
      m             <= 3'd0;
    end else begin
      ser_en_q      <= ser_en;
      clk_mdpx      <= ser_clk;
      data_mdpx     <= ser_data;
      en_mdpx       <= ser_en;
      shutter_mdpx  <= shutter;
      reset_mdpx    <= chip_reset;
      cont_sel_mdpx <= cont_sel;
      mtx_clr_mdpx  <= mtx_clr;
      tpswt_mdpx    <= tpswt;
      // M follows the new mode together with the first cycle of en_mdpx.
      if (ser_en_rise) begin
        m <= omr_mode;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/medipix_bridge.sv
// Medipix bridge top level
`timescale 1ns/1ps
`default_nettype none

module medipix_bridge (
  input  logic       clk_nios,
  input  logic       rst_n,
  input  logic       en_nios,
  input  logic       sync_nios,
  input  logic [7:0] data_nios,
  output logic       clk_mdpx,
  output logic       data_mdpx,
  output logic       en_mdpx,
  output logic       shutter_mdpx,
  output logic       reset_mdpx,
  output logic       cont_sel_mdpx,
  output logic       mtx_clr_mdpx,
  output logic       tpswt_mdpx,
  output logic [2:0] m
);

  import mdpx_omr_pkg::*;

  omr_t       omr;
  logic       send_omr;
  logic       busy;
  logic       shutter;
  logic       chip_reset;
  logic       cont_sel;
  logic       mtx_clr;
  logic       tpswt;
  logic       ser_clk;
  logic       ser_data;
  logic       ser_en;
  logic [2:0] omr_mode;

  omr_decoder decoder_i (
    .clk_nios   (clk_nios),
    .rst_n      (rst_n),
    .en_nios    (en_nios),
    .sync_nios  (sync_nios),
    .data_nios  (data_nios),
    .busy       (busy),
    .omr        (omr),
    .send_omr   (send_omr),
    .shutter    (shutter),
    .chip_reset (chip_reset),
    .cont_sel   (cont_sel),
    .mtx_clr    (mtx_clr),
    .tpswt      (tpswt)
  );

  omr_burst burst_i (
    .clk_nios (clk_nios),
    .rst_n    (rst_n),
    .send_omr (send_omr),
    .omr      (omr),
    .busy     (busy),
    .ser_clk  (ser_clk),
    .ser_data (ser_data),
    .ser_en   (ser_en),
    .omr_mode (omr_mode)
  );

  mdpx_pin_driver pins_i (
    .clk_nios      (clk_nios),
    .rst_n         (rst_n),
    .shutter       (shutter),
    .chip_reset    (chip_reset),
    .cont_sel      (cont_sel),
    .mtx_clr       (mtx_clr),
    .tpswt         (tpswt),
    .ser_clk       (ser_clk),
    .ser_data      (ser_data),
    .ser_en        (ser_en),
    .omr_mode      (omr_mode),
    .clk_mdpx      (clk_mdpx),
    .data_mdpx     (data_mdpx),
    .en_mdpx       (en_mdpx),
    .shutter_mdpx  (shutter_mdpx),
    .reset_mdpx    (reset_mdpx),
    .cont_sel_mdpx (cont_sel_mdpx),
    .mtx_clr_mdpx  (mtx_clr_mdpx),
    .tpswt_mdpx    (tpswt_mdpx),
    .m             (m)
  );

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  localparam int unsigned PERIOD_NS    = 40;
  localparam int unsigned RESET_CYCLES = 3;

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  // Reset is released on a falling edge, away from the sampling edge.
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

//--- verification/medipix_bridge_asserts.sv
// OMR burst assertions
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module medipix_bridge_asserts (
  input logic clk_nios,
  input logic rst_n,
  input logic ser_en,
  input logic ser_clk
);

  localparam int unsigned BURST_CYCLES = `MDPX_OMR_BITS * 2 * `MDPX_HALF_PERIOD;

  int unsigned run_len;
  int unsigned failures = 0;

  // Length of the current ser_en run, in cycles.
  always_ff @(posedge clk_nios) begin
    if (!rst_n) begin
      run_len <= 0;
    end else if (ser_en) begin
      run_len <= run_len + 1;
    end else begin
      run_len <= 0;
    end
  end

  burst_not_too_long: assert property (@(posedge clk_nios) disable iff (!rst_n)
    ser_en |-> (run_len < BURST_CYCLES))
    else begin
      failures++;
      $error("ser_en stayed high for more than one burst");
    end

  burst_exact_length: assert property (@(posedge clk_nios) disable iff (!rst_n)
    $fell(ser_en) |-> (run_len == BURST_CYCLES))
    else begin
      failures++;
      $error("ser_en fell after %0d cycles", run_len);
    end

  clk_low_when_idle: assert property (@(posedge clk_nios) disable iff (!rst_n)
    !ser_en |-> !ser_clk)
    else begin
      failures++;
      $error("ser_clk high while ser_en is low");
    end

endmodule

bind omr_burst medipix_bridge_asserts burst_checks_i (
  .clk_nios (clk_nios),
  .rst_n    (rst_n),
  .ser_en   (ser_en),
  .ser_clk  (ser_clk)
);

`default_nettype wire

//--- verification/medipix_bridge_tb.sv
// Medipix bridge testbench
`timescale 1ns/1ps
`default_nettype none

`include "bridge_settings.svh"

module medipix_bridge_tb;

  import bridge_cmd_pkg::*;

  localparam int unsigned N_ROUNDS     = 40;
  localparam int unsigned MAX_CYCLES   = N_ROUNDS * 120 + 500;
  localparam int unsigned BURST_CYCLES = `MDPX_OMR_BITS * 2 * `MDPX_HALF_PERIOD;

  logic       clk_nios;
  logic       rst_n;
  logic       en_nios;
  logic       sync_nios;
  logic [7:0] data_nios;
  logic       clk_mdpx;
  logic       data_mdpx;
  logic       en_mdpx;
  logic       shutter_mdpx;
  logic       reset_mdpx;
  logic       cont_sel_mdpx;
  logic       mtx_clr_mdpx;
  logic       tpswt_mdpx;
  logic [2:0] m;
  logic [4:0] level_pins;

  logic [47:0] exp_omrs[$];
  logic [4:0]  exp_levels = '0;
  logic [47:0] cur_omr = '0;
  logic [47:0] got_bits = '0;
  logic        in_burst = 1'b0;
  logic        clk_prev = 1'b0;
  int unsigned en_cycles = 0;
  int unsigned n_bits = 0;
  int unsigned n_checks = 0;
  int unsigned n_errors = 0;
  int unsigned cycles = 0;
  int unsigned seed_value;

  tb_clock_gen clock_i (
    .clk   (clk_nios),
    .rst_n (rst_n)
  );

  medipix_bridge dut_i (
    .clk_nios      (clk_nios),
    .rst_n         (rst_n),
    .en_nios       (en_nios),
    .sync_nios     (sync_nios),
    .data_nios     (data_nios),
    .clk_mdpx      (clk_mdpx),
    .data_mdpx     (data_mdpx),
    .en_mdpx       (en_mdpx),
    .shutter_mdpx  (shutter_mdpx),
    .reset_mdpx    (reset_mdpx),
    .cont_sel_mdpx (cont_sel_mdpx),
    .mtx_clr_mdpx  (mtx_clr_mdpx),
    .tpswt_mdpx    (tpswt_mdpx),
    .m             (m)
  );

  // Bit order follows the control byte. Shutter is bit 0 and the test-pulse switch bit 4.
  assign level_pins = {tpswt_mdpx, mtx_clr_mdpx, cont_sel_mdpx, reset_mdpx, shutter_mdpx};

  task automatic check_value(input logic [63:0] got, input logic [63:0] exp,
                             input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Mismatch at time %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
    end
  endtask

  function automatic logic [47:0] random_omr();
    return 48'({$urandom, $urandom});
  endfunction

  task automatic send_byte(input logic sync, input logic [7:0] data);
    @(negedge clk_nios);
    en_nios   = 1'b1;
    sync_nios = sync;
    data_nios = data;
  endtask

  task automatic bus_idle(input int unsigned n);
    repeat (n) begin
      @(negedge clk_nios);
      en_nios   = 1'b0;
      sync_nios = 1'b0;
      data_nios = 8'($urandom);
    end
  endtask

  // An accepted write must raise en_mdpx three edges after its last byte is sampled.
  task automatic write_omr(input logic [47:0] value, input logic accepted);
    int unsigned wait_cycles;
    send_byte(1'b1, OP_WRITE_OMR);
    for (int i = 5; i >= 0; i--) begin
      bus_idle($urandom_range(0, 1));
      send_byte(1'b0, value[i*8 +: 8]);
    end
    if (accepted) begin
      exp_omrs.push_back(value);
    end
    bus_idle(1);
    if (accepted) begin
      wait_cycles = 0;
      while (!en_mdpx && wait_cycles < 10) begin
        @(negedge clk_nios);
        wait_cycles++;
      end
      check_value(wait_cycles, 3, "cycles from the last OMR byte to en_mdpx");
      // Payload past the sixth byte is ignored.
      repeat ($urandom_range(0, 2)) begin
        send_byte(1'b0, 8'($urandom));
      end
      bus_idle(1);
    end
  endtask

  task automatic write_levels(input logic [7:0] ctl);
    logic [4:0] old_levels;
    old_levels = exp_levels;
    send_byte(1'b1, OP_SET_LEVELS);
    bus_idle($urandom_range(0, 1));
    send_byte(1'b0, ctl);
    bus_idle(2);
    check_value(level_pins, old_levels, "control pins one edge after the level byte");
    @(negedge clk_nios);
    exp_levels = ctl[4:0];
    check_value(level_pins, exp_levels, "control pins two edges after the level byte");
    repeat ($urandom_range(0, 2)) begin
      send_byte(1'b0, 8'($urandom));
    end
    bus_idle(1);
  endtask

  task automatic check_levels_hold();
    bus_idle(3);
    check_value(level_pins, exp_levels, "control pins after a frame");
  endtask

  task automatic write_unknown();
    logic [7:0] op;
    op = 8'($urandom);
    while (op == OP_WRITE_OMR || op == OP_SET_LEVELS) begin
      op = 8'($urandom);
    end
    send_byte(1'b1, op);
    repeat ($urandom_range(1, 7)) begin
      send_byte(1'b0, 8'($urandom));
    end
    check_levels_hold();
  endtask

  task automatic abort_omr();
    send_byte(1'b1, OP_WRITE_OMR);
    repeat ($urandom_range(1, 5)) begin
      send_byte(1'b0, 8'($urandom));
    end
  endtask

  task automatic wait_burst_end();
    while (en_mdpx) begin
      @(negedge clk_nios);
    end
    bus_idle(2);
  endtask

  // Burst monitor. Bits are taken where clk_mdpx was seen rising.
  always @(negedge clk_nios) begin
    if (rst_n) begin
      if (en_mdpx) begin
        if (!in_burst) begin
          in_burst  = 1'b1;
          en_cycles = 0;
          n_bits    = 0;
          if (exp_omrs.size() == 0) begin
            n_errors++;
            $display("Error at time %0t: a burst started with no OMR write pending", $time);
            cur_omr = '0;
          end else begin
            cur_omr = exp_omrs.pop_front();
          end
          check_value(m, cur_omr[47:45], "m at the first cycle of en_mdpx");
        end
        en_cycles++;
        if (clk_mdpx && !clk_prev) begin
          got_bits = {got_bits[46:0], data_mdpx};
          n_bits++;
        end
      end else begin
        if (in_burst) begin
          in_burst = 1'b0;
          check_value(en_cycles, BURST_CYCLES, "en_mdpx high cycles");
          check_value(n_bits, `MDPX_OMR_BITS, "clk_mdpx rising edges in a burst");
          check_value(got_bits, cur_omr, "OMR bits on data_mdpx");
        end
        check_value({clk_mdpx, data_mdpx}, 2'b00, "clk_mdpx and data_mdpx outside a burst");
      end
      clk_prev = clk_mdpx;
    end
  end

  always @(posedge clk_nios) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      $display("TB FAILED");
      $finish;
    end
  end

  initial begin
    seed_value = $urandom(74);
    en_nios    = 1'b0;
    sync_nios  = 1'b0;
    data_nios  = 8'h00;
    wait (rst_n === 1'b1);
    @(negedge clk_nios);
    check_value({clk_mdpx, data_mdpx, en_mdpx, level_pins, m}, '0, "pins after reset");

    for (int r = 0; r < N_ROUNDS; r++) begin
      case ($urandom_range(0, 4))
        0: begin
          write_omr(random_omr(), 1'b1);
          wait_burst_end();
        end
        1: begin
          write_levels(8'($urandom));
          check_levels_hold();
        end
        2: begin
          write_unknown();
        end
        3: begin
          abort_omr();
          write_omr(random_omr(), 1'b1);
          wait_burst_end();
        end
        default: begin
          // The second write completes during the burst and must be dropped.
          write_omr(random_omr(), 1'b1);
          write_omr(random_omr(), 1'b0);
          write_levels(8'($urandom));
          wait_burst_end();
        end
      endcase
    end

    bus_idle(4);
    check_value(exp_omrs.size(), 0, "OMR writes still waiting for a burst");
    n_errors += dut_i.burst_i.burst_checks_i.failures;
    $display("Checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- build.f
+incdir+design
design/mdpx_omr_pkg.sv
design/bridge_cmd_pkg.sv
design/omr_decoder.sv
design/omr_burst.sv
design/mdpx_pin_driver.sv
design/medipix_bridge.sv
verification/tb_clock_gen.sv
verification/medipix_bridge_asserts.sv
verification/medipix_bridge_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= medipix_bridge_tb
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing --assert
PASS_TEXT  ?= TB PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "^$(PASS_TEXT)$$" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
